// File: verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ############################################################################
// cache geometry.
// ############################################################################

// address and data word width in bits.
`define DCACHE_WORD_SIZE   32

// byte offset bits within a line, so a line is 16 bytes.
`define DCACHE_OFFSET_SIZE 4

// index bits, one lane per index value.
`define DCACHE_INDEX_SIZE  2

// whatever the index and offset leave over is tag.
`define DCACHE_TAG_SIZE    (`DCACHE_WORD_SIZE - `DCACHE_INDEX_SIZE - `DCACHE_OFFSET_SIZE)

`define DCACHE_LINE_WORDS  4

`endif

// File: verilog/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    // ########################################################################
    // address views.
    // ########################################################################

    // field order follows the bit order of the address, tag on top.
    typedef struct packed {
        logic [`DCACHE_TAG_SIZE-1:0]    tag;
        logic [`DCACHE_INDEX_SIZE-1:0]  index;
        logic [`DCACHE_OFFSET_SIZE-1:0] offset;
    } dcache_addr_fields_t;

    // the same address word, read flat or by field.
    typedef union packed {
        logic [`DCACHE_WORD_SIZE-1:0] word;
        dcache_addr_fields_t          f;
    } dcache_addr_u;

    // ########################################################################
    // line and response.
    // ########################################################################

    // word 0 of the line sits at the lowest byte address.
    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_WORD_SIZE-1:0] dcache_line_t;

    typedef struct packed {
        logic [`DCACHE_WORD_SIZE-1:0] data;
        logic                         hit;
    } dcache_rsp_t;

endpackage : dcache_pkg

// File: verilog/dcache_tag.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tag (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     lookup_i,
    input  dcache_pkg::dcache_addr_u lookup_addr_i,
    input  logic                     fill_i,
    input  dcache_pkg::dcache_addr_u fill_addr_i,
    input  logic                     flush_i,
    output logic                     hit_o,
    output logic                     miss_o
);
    import dcache_pkg::*;

    localparam int NUM_LANES = 1 << `DCACHE_INDEX_SIZE;

    logic [NUM_LANES-1:0]        valid_q;
    logic [`DCACHE_TAG_SIZE-1:0] tag_q [NUM_LANES];
    logic                        lane_valid;
    logic                        tag_equal;

    // ########################################################################
    // valid bits and tags.
    // ########################################################################

    // flush and fill never share a cycle since the controller flushes only
    // while idle, but flush is given priority all the same.
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_addr_i.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_addr_i.f.index] <= fill_addr_i.f.tag;
        end
    end

    // ########################################################################
    // lookup.
    // ########################################################################

    // direct mapped, so only the addressed lane can hold the line.
    assign lane_valid = valid_q[lookup_addr_i.f.index];
    assign tag_equal  = (tag_q[lookup_addr_i.f.index] == lookup_addr_i.f.tag);

    assign hit_o  = lookup_i & lane_valid & tag_equal;
    assign miss_o = lookup_i & ~(lane_valid & tag_equal);

endmodule : dcache_tag

// File: verilog/dcache_data.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_data (
    input  logic                         clk_i,
    input  dcache_pkg::dcache_addr_u     rd_addr_i,
    output logic [`DCACHE_WORD_SIZE-1:0] rd_data_o,
    input  logic                         fill_i,
    input  dcache_pkg::dcache_addr_u     fill_addr_i,
    input  dcache_pkg::dcache_line_t     fill_line_i
);
    import dcache_pkg::*;

    localparam int NUM_LANES = 1 << `DCACHE_INDEX_SIZE;
    localparam int BYTE_BITS = $clog2(`DCACHE_WORD_SIZE / 8);
    localparam int WSEL_BITS = $clog2(`DCACHE_LINE_WORDS);

    dcache_line_t         lines_q [NUM_LANES];
    dcache_line_t         staged_q;
    dcache_line_t         rd_line;
    logic [WSEL_BITS-1:0] word_sel;
    logic                 fill_hit;

    // ########################################################################
    // line storage.
    // ########################################################################

    // the memory line is valid one cycle ahead of the fill strobe, so it is
    // captured every cycle and the fill writes the captured copy.
    always_ff @(posedge clk_i) begin
        staged_q <= fill_line_i;
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines_q[fill_addr_i.f.index] <= staged_q;
        end
    end

    // ########################################################################
    // word read.
    // ########################################################################

    // a read of the lane being filled sees the incoming line, which lets the
    // controller register the miss word in the fill cycle itself.
    assign fill_hit = fill_i && (fill_addr_i.f.index == rd_addr_i.f.index);
    assign rd_line  = fill_hit ? staged_q : lines_q[rd_addr_i.f.index];

    assign word_sel  = rd_addr_i.f.offset[BYTE_BITS +: WSEL_BITS];
    assign rd_data_o = rd_line[word_sel];

endmodule : dcache_data

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  dcache_pkg::dcache_addr_u     addr_i,
    input  logic                         invalidate_i,
    output logic                         ready_o,
    output logic                         rvalid_o,
    output dcache_pkg::dcache_rsp_t      rsp_o,
    output logic                         lookup_o,
    output dcache_pkg::dcache_addr_u     lookup_addr_o,
    input  logic                         hit_i,
    input  logic                         miss_i,
    output logic                         flush_o,
    output logic                         fill_o,
    output dcache_pkg::dcache_addr_u     fill_addr_o,
    input  logic [`DCACHE_WORD_SIZE-1:0] rd_data_i,
    output logic                         mem_req_o,
    output dcache_pkg::dcache_addr_u     mem_addr_o,
    input  logic                         mem_valid_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_MEM,
        ST_FILL
    } state_e;

    state_e       state_q;
    state_e       state_d;
    dcache_addr_u miss_addr_q;
    dcache_rsp_t  rsp_q;
    logic         rvalid_q;
    logic         mem_req_q;
    logic         accept_req;

    // ########################################################################
    // request acceptance.
    // ########################################################################

    assign ready_o = (state_q == ST_IDLE);

    // invalidate wins over a load in the same cycle.
    assign accept_req = ready_o & req_i & ~invalidate_i;
    assign flush_o    = ready_o & invalidate_i;

    assign lookup_o      = accept_req;
    assign lookup_addr_o = (state_q == ST_IDLE) ? addr_i : miss_addr_q;

    assign fill_o      = (state_q == ST_FILL);
    assign fill_addr_o = miss_addr_q;

    // line requests are always line aligned.
    always_comb begin
        mem_addr_o          = miss_addr_q;
        mem_addr_o.f.offset = '0;
    end

    assign mem_req_o = mem_req_q;
    assign rvalid_o  = rvalid_q;
    assign rsp_o     = rsp_q;

    // ########################################################################
    // miss FSM.
    // ########################################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (accept_req && miss_i) state_d = ST_WAIT_MEM;
            ST_WAIT_MEM: if (mem_valid_i) state_d = ST_FILL;
            ST_FILL:     state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            mem_req_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            mem_req_q <= accept_req & miss_i;
            rvalid_q  <= (accept_req & hit_i) | fill_o;
        end
    end

    // during the fill cycle the line store forwards the incoming line, so
    // rd_data_i already holds the missed word.
    always_ff @(posedge clk_i) begin
        if (accept_req && miss_i) begin
            miss_addr_q <= addr_i;
        end
        if (accept_req && hit_i) begin
            rsp_q.data <= rd_data_i;
            rsp_q.hit  <= 1'b1;
        end else if (fill_o) begin
            rsp_q.data <= rd_data_i;
            rsp_q.hit  <= 1'b0;
        end
    end

endmodule : dcache_ctrl

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     req_i,
    input  dcache_pkg::dcache_addr_u addr_i,
    input  logic                     invalidate_i,
    output logic                     ready_o,
    output logic                     rvalid_o,
    output dcache_pkg::dcache_rsp_t  rsp_o,
    output logic                     mem_req_o,
    output dcache_pkg::dcache_addr_u mem_addr_o,
    input  logic                     mem_valid_i,
    input  dcache_pkg::dcache_line_t mem_line_i
);
    import dcache_pkg::*;

    logic                         lookup;
    dcache_addr_u                 lookup_addr;
    logic                         hit;
    logic                         miss;
    logic                         flush;
    logic                         fill;
    dcache_addr_u                 fill_addr;
    logic [`DCACHE_WORD_SIZE-1:0] rd_data;

    dcache_ctrl i_dcache_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .invalidate_i  (invalidate_i),
        .ready_o       (ready_o),
        .rvalid_o      (rvalid_o),
        .rsp_o         (rsp_o),
        .lookup_o      (lookup),
        .lookup_addr_o (lookup_addr),
        .hit_i         (hit),
        .miss_i        (miss),
        .flush_o       (flush),
        .fill_o        (fill),
        .fill_addr_o   (fill_addr),
        .rd_data_i     (rd_data),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i)
    );

    dcache_tag i_dcache_tag (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_i      (lookup),
        .lookup_addr_i (lookup_addr),
        .fill_i        (fill),
        .fill_addr_i   (fill_addr),
        .flush_i       (flush),
        .hit_o         (hit),
        .miss_o        (miss)
    );

    // the line store is read at the lookup address, held miss address included.
    dcache_data i_dcache_data (
        .clk_i       (clk_i),
        .rd_addr_i   (lookup_addr),
        .rd_data_o   (rd_data),
        .fill_i      (fill),
        .fill_addr_i (fill_addr),
        .fill_line_i (mem_line_i)
    );

endmodule : dcache_top

// File: verif/dcache_chk.sv
`timescale 1ns/1ns

module dcache_chk (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    req_i,
    input logic                    invalidate_i,
    input logic                    ready_i,
    input logic                    rvalid_i,
    input dcache_pkg::dcache_rsp_t rsp_i,
    input logic                    mem_req_i,
    input logic                    mem_valid_i,
    input logic                    hit_i,
    input logic                    miss_i
);
    import dcache_pkg::*;

    int   fail_count = 0;
    logic line_pending_q;
    logic accept_req;

    assign accept_req = ready_i & req_i & ~invalidate_i;

    // a line request stays outstanding until memory returns the line.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            line_pending_q <= 1'b0;
        end else if (mem_req_i) begin
            line_pending_q <= 1'b1;
        end else if (mem_valid_i) begin
            line_pending_q <= 1'b0;
        end
    end

    // ########################################################################
    // protocol rules.
    // ########################################################################

    mem_req_once: assert property (@(posedge clk_i) disable iff (rst_i)
        line_pending_q |-> !mem_req_i)
    else begin
        $error("mem_req_o raised again before mem_valid_i");
        fail_count++;
    end

    miss_drops_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (accept_req && miss_i) |=> !ready_i)
    else begin
        $error("ready_o stayed high in the cycle after an accepted miss");
        fail_count++;
    end

    hit_response: assert property (@(posedge clk_i) disable iff (rst_i)
        (accept_req && hit_i) |=> (rvalid_i && rsp_i.hit))
    else begin
        $error("no hit response one cycle after an accepted hit");
        fail_count++;
    end

    reset_values: assert property (@(posedge clk_i)
        rst_i |=> (ready_i && !rvalid_i && !mem_req_i))
    else begin
        $error("ready_o, rvalid_o or mem_req_o left its reset value during reset");
        fail_count++;
    end

endmodule : dcache_chk

bind dcache_top dcache_chk i_dcache_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .invalidate_i (invalidate_i),
    .ready_i      (ready_o),
    .rvalid_i     (rvalid_o),
    .rsp_i        (rsp_o),
    .mem_req_i    (mem_req_o),
    .mem_valid_i  (mem_valid_i),
    .hit_i        (hit),
    .miss_i       (miss)
);

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          MAX_WORDS      = 512;
    localparam logic [31:0] DATA_KEY       = 32'hC0DE0000;
    localparam logic [31:0] OP_LOAD        = 32'h0;
    localparam logic [31:0] OP_INVAL       = 32'h1;
    localparam logic [31:0] OP_END         = 32'hF;

    typedef struct packed {
        logic [31:0] test_num;
        logic [31:0] addr;
        logic [31:0] data;
        logic        hit;
        logic [31:0] issue_cycle;
    } pending_t;

    logic         clk;
    logic         rst;
    logic         req;
    dcache_addr_u addr;
    logic         invalidate;
    logic         ready;
    logic         rvalid;
    dcache_rsp_t  rsp;
    logic         mem_req;
    dcache_addr_u mem_addr;
    logic         mem_valid;
    dcache_line_t mem_line;

    logic [31:0]  cmd_mem [MAX_WORDS];
    pending_t     pending [$];
    int unsigned  cycle_count;
    int           error_count;
    int           tests_passed;
    int           tests_failed;
    int           stall_cycles;
    logic         mem_busy;
    int           mem_delay;
    dcache_addr_u mem_base;

    // the word at byte address a holds a xor DATA_KEY.
    function automatic logic [31:0] rule_word(input logic [31:0] byte_addr);
        return {byte_addr[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    function automatic dcache_line_t build_line(input logic [31:0] base);
        dcache_line_t line;
        for (int i = 0; i < `DCACHE_LINE_WORDS; i++) begin
            line[i] = rule_word(base + 32'(4 * i));
        end
        return line;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic wait_for_ready(input int test_num);
        int waited;
        waited = 0;
        while (!ready && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready) begin
            report_timeout($sformatf("ready_o stayed low before test %0d", test_num));
        end
    endtask

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    dcache_top i_dcache_top (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_i        (req),
        .addr_i       (addr),
        .invalidate_i (invalidate),
        .ready_o      (ready),
        .rvalid_o     (rvalid),
        .rsp_o        (rsp),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_valid_i  (mem_valid),
        .mem_line_i   (mem_line)
    );

    // ########################################################################
    // line memory with a random latency of 1 to 6 cycles.
    // ########################################################################

    // the line request belongs to the newest load, which is the miss.
    always @(posedge clk) begin : line_memory
        logic [31:0] exp_base;
        #1;
        mem_valid = 1'b0;
        mem_line  = '0;
        if (rst) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_delay == 0) begin
                mem_valid = 1'b1;
                mem_line  = build_line(mem_base.word);
                mem_busy  = 1'b0;
            end else begin
                mem_delay--;
            end
        end else if (mem_req) begin
            exp_base = {pending[$].addr[31:4], 4'h0};
            assert (mem_addr.word == exp_base) else begin
                $display("mismatch at %0t: mem_addr_o got %h expected %h",
                         $time, mem_addr.word, exp_base);
                error_count++;
            end
            mem_base  = mem_addr;
            mem_delay = $urandom_range(6, 1) - 1;
            mem_busy  = 1'b1;
        end
    end

    // ########################################################################
    // response checks, in request order.
    // ########################################################################

    always @(posedge clk) begin : response_check
        pending_t exp;
        logic     ok;
        #1;
        if (rst) begin
            stall_cycles = 0;
        end else if (rvalid) begin
            stall_cycles = 0;
            assert (pending.size() != 0) else begin
                $display("rvalid_o pulsed at %0t with no load outstanding", $time);
                error_count++;
            end
            if (pending.size() != 0) begin
                exp = pending.pop_front();
                ok  = 1'b1;
                assert (rsp.hit == exp.hit) else begin
                    $display("mismatch at %0t: rsp_o.hit got %0b expected %0b",
                             $time, rsp.hit, exp.hit);
                    ok = 1'b0;
                end
                assert (rsp.data == exp.data) else begin
                    $display("mismatch at %0t: rsp_o.data got %h expected %h",
                             $time, rsp.data, exp.data);
                    ok = 1'b0;
                end
                if (exp.hit) begin
                    assert (cycle_count == exp.issue_cycle + 1) else begin
                        $display("hit of test %0d answered %0d cycles after its request",
                                 exp.test_num, cycle_count - exp.issue_cycle);
                        ok = 1'b0;
                    end
                end else begin
                    assert (ready) else begin
                        $display("ready_o still low with the miss response of test %0d",
                                 exp.test_num);
                        ok = 1'b0;
                    end
                end
                if (ok) begin
                    tests_passed++;
                    $display("test %0d load %h: ok", exp.test_num, exp.addr);
                end else begin
                    tests_failed++;
                    error_count++;
                    $display("test %0d load %h: failed", exp.test_num, exp.addr);
                end
            end
        end else if (pending.size() != 0) begin
            stall_cycles++;
            exp = pending[0];
            if (stall_cycles > TIMEOUT_CYCLES) begin
                report_timeout("no rvalid_o for an outstanding load");
            end else if (!exp.hit && cycle_count > exp.issue_cycle) begin
                // a miss keeps ready_o low until its response.
                assert (!ready) else begin
                    $display("ready_o high at %0t while the miss of test %0d waits",
                             $time, exp.test_num);
                    error_count++;
                end
            end
        end
    end

    // ########################################################################
    // stimulus from the command file.
    // ########################################################################

    initial begin : stimulus
        logic [31:0] op;
        int          idx;
        int          test_num;
        int          waited;
        pending_t    item;

        void'($urandom(32'h8729));
        rst          = 1'b1;
        req          = 1'b0;
        addr         = '0;
        invalidate   = 1'b0;
        mem_valid    = 1'b0;
        mem_line     = '0;
        mem_busy     = 1'b0;
        cycle_count  = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            cmd_mem[i] = OP_END;
        end
        $readmemh("verif/dcache_input.txt", cmd_mem);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        idx = 0;
        while (idx + 3 < MAX_WORDS && cmd_mem[idx] != OP_END) begin
            op       = cmd_mem[idx];
            test_num = idx / 4 + 1;
            wait_for_ready(test_num);
            if (op == OP_INVAL) begin
                // the loads that follow show whether the lanes were cleared.
                invalidate = 1'b1;
                $display("test %0d invalidate: issued", test_num);
            end else if (op == OP_LOAD) begin
                item.test_num    = test_num;
                item.addr        = cmd_mem[idx + 1];
                item.hit         = cmd_mem[idx + 2][0];
                item.data        = cmd_mem[idx + 3];
                item.issue_cycle = cycle_count;
                assert (item.data == rule_word(item.addr)) else begin
                    $display("test %0d expects %h at %h, against the memory rule",
                             test_num, item.data, item.addr);
                    error_count++;
                end
                req       = 1'b1;
                addr.word = item.addr;
                pending.push_back(item);
            end else begin
                $display("test %0d has an unknown operation %h", test_num, op);
                error_count++;
            end
            @(posedge clk);
            #1;
            req        = 1'b0;
            invalidate = 1'b0;
            idx += 4;
        end

        waited = 0;
        while (pending.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending.size() != 0) begin
            report_timeout("responses still outstanding after the last command");
        end
        repeat (2) @(posedge clk);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count,
                 i_dcache_top.i_dcache_chk.fail_count);
        if (error_count == 0 && tests_failed == 0
                && i_dcache_top.i_dcache_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : dcache_tb

// File: project.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag.sv
verilog/dcache_data.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

// File: verif/dcache_input.txt
// columns: op (0 load, 1 invalidate, f end), byte address, expected hit flag, expected word.
// all values are hex; an invalidate line carries zeros in the other columns.
0 00001000 0 c0de1000
0 00001014 0 c0de1014
0 00001028 0 c0de1028
0 0000103c 0 c0de103c
0 00001004 1 c0de1004
0 00001018 1 c0de1018
0 00001020 1 c0de1020
0 00001030 1 c0de1030
0 0000100c 1 c0de100c
0 00001010 1 c0de1010
0 0000102c 1 c0de102c
0 00001038 1 c0de1038
0 00001000 1 c0de1000
0 00002000 0 c0de2000
0 00002008 1 c0de2008
0 00001004 0 c0de1004
0 00002004 0 c0de2004
0 0000a510 0 c0dea510
0 0000101c 0 c0de101c
0 12345670 0 d2ea5670
0 1234567c 1 d2ea567c
0 0000103c 0 c0de103c
1 00000000 0 00000000
0 00002008 0 c0de2008
0 0000200c 1 c0de200c
0 00001024 0 c0de1024
0 00001020 1 c0de1020
0 fffffff0 0 3f21fff0
0 fffffff4 1 3f21fff4
0 80000010 0 40de0010
0 80000018 1 40de0018
1 00000000 0 00000000
0 80000014 0 40de0014
0 8000001c 1 40de001c
0 fffffffc 0 3f21fffc
f 00000000 0 00000000
